//--- axi_wjoin.f
hdl/axi_wjoin_pkg.sv
hdl/axi_fifo.sv
hdl/wjoin_burst_ctrl.sv
hdl/wjoin_beat_out.sv
hdl/axi_wjoin_top.sv
dv/tb_clk_gen.sv
dv/axi_wjoin_tb.sv

//--- Bender.yml
package:
  name: axi_wjoin

sources:
  - hdl/axi_wjoin_pkg.sv
  - hdl/axi_fifo.sv
  - hdl/wjoin_burst_ctrl.sv
  - hdl/wjoin_beat_out.sv
  - hdl/axi_wjoin_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/axi_wjoin_tb.sv

//--- dv/axi_wjoin_tb.sv
/*
 * write join testbench
 * random bursts from an LFSR, in-order beat model, stall and flush scenarios
 */
`timescale 1ns/1ps
`default_nettype none

module axi_wjoin_tb;

    // bursts per test summed for the run limit
    localparam int N_BURSTS  = 6 + 10 + 6 + 5 + 1 + 2 + 1;
    localparam int MAX_BEATS = N_BURSTS * 16;
    localparam int LIMIT     = MAX_BEATS * 20;
    localparam int FILL_WAIT = 40;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   flush;
    axi_wjoin_pkg::aw_req_t                 aw_in;
    logic                                   aw_push;
    logic                                   aw_full;
    axi_wjoin_pkg::w_beat_t                 w_in;
    logic                                   w_push;
    logic                                   w_full;
    logic                                   stall;
    axi_wjoin_pkg::out_beat_t               beat;
    logic                                   beat_valid;
    logic                                   burst_done;
    logic [axi_wjoin_pkg::ID_W-1:0]         done_id;
    logic                                   last_err;

    // source queues and expected output stream
    axi_wjoin_pkg::aw_req_t                 aw_src[$];
    axi_wjoin_pkg::w_beat_t                 w_src[$];
    axi_wjoin_pkg::out_beat_t               exp_q[$];

    logic [31:0] lfsr_q;
    string       cur_test;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          done_cnt;
    int          err_pulses;
    int          cycle_cnt;
    int          n;

    tb_clk_gen clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    axi_wjoin_top axi_wjoin_top_inst (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .flush_i      (flush),
        .aw_i         (aw_in),
        .aw_push_i    (aw_push),
        .aw_full_o    (aw_full),
        .w_i          (w_in),
        .w_push_i     (w_push),
        .w_full_o     (w_full),
        .stall_i      (stall),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .burst_done_o (burst_done),
        .done_id_o    (done_id),
        .last_err_o   (last_err)
    );

    // galois LFSR with polynomial x^32+x^22+x^2+x+1 stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] v;
        logic        b;
        int          i;
        v = '0;
        for (i = 0; i < nbits; i++) begin
            b      = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
            v = {v[62:0], b};
        end
        return v;
    endfunction

    task automatic check_value(input string label, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %s/%s: expected %h, actual %h", cur_test, label, exp_v, act_v);
            errors++;
            test_errs++;
        end
    endtask

    // one request plus its beats with a random length when len_sel is negative
    task automatic gen_burst(input int len_sel, input bit bad_last);
        axi_wjoin_pkg::aw_req_t   req;
        axi_wjoin_pkg::w_beat_t   wb;
        axi_wjoin_pkg::out_beat_t eb;
        logic [63:0]              r;
        int                       nbeats;
        int                       k;
        r        = rand_bits(axi_wjoin_pkg::ID_W);
        req.id   = r[axi_wjoin_pkg::ID_W-1:0];
        r        = rand_bits(axi_wjoin_pkg::ADDR_W);
        req.addr = r[axi_wjoin_pkg::ADDR_W-1:0];
        r        = rand_bits(axi_wjoin_pkg::LEN_W);
        req.len  = (len_sel < 0) ? r[axi_wjoin_pkg::LEN_W-1:0] : len_sel[axi_wjoin_pkg::LEN_W-1:0];
        nbeats   = int'(req.len) + 1;
        aw_src.push_back(req);
        for (k = 0; k < nbeats; k++) begin
            r       = rand_bits(axi_wjoin_pkg::DATA_W);
            wb.data = r;
            r       = rand_bits(axi_wjoin_pkg::STRB_W);
            wb.strb = r[axi_wjoin_pkg::STRB_W-1:0];
            wb.last = (k == nbeats - 1);
            // early last on the first beat of a multi-beat burst
            if (bad_last && k == 0) wb.last = 1'b1;
            w_src.push_back(wb);
            // expected address steps by bytes per beat and last follows len only
            eb.id   = req.id;
            eb.addr = req.addr + axi_wjoin_pkg::STRB_W * k;
            eb.data = wb.data;
            eb.strb = wb.strb;
            eb.last = (k == nbeats - 1);
            exp_q.push_back(eb);
        end
    endtask

    // drive on the falling edge and sample once settled
    task automatic cycle_step(input logic stall_val);
        axi_wjoin_pkg::out_beat_t eb;
        @(negedge clk);
        aw_push = 1'b0;
        w_push  = 1'b0;
        if (aw_src.size() > 0 && !aw_full) begin
            aw_in   = aw_src.pop_front();
            aw_push = 1'b1;
        end
        if (w_src.size() > 0 && !w_full) begin
            w_in   = w_src.pop_front();
            w_push = 1'b1;
        end
        stall = stall_val;
        #1;
        if (last_err) err_pulses++;
        if (burst_done) done_cnt++;
        if (beat_valid && !stall) begin
            if (exp_q.size() == 0) begin
                $display("%s: a beat was delivered although none was expected", cur_test);
                errors++;
                test_errs++;
            end else begin
                eb = exp_q.pop_front();
                check_value("beat", 128'(eb), 128'(beat));
                check_value("burst_done", 128'(eb.last), 128'(burst_done));
                if (eb.last) begin
                    check_value("done_id", 128'(eb.id), 128'(done_id));
                end
            end
        end else begin
            check_value("burst_done idle", 128'(0), 128'(burst_done));
        end
    endtask

    // run until every pushed beat came out
    task automatic drain(input bit random_stall);
        logic [63:0] r;
        while (aw_src.size() > 0 || w_src.size() > 0 || exp_q.size() > 0) begin
            r = random_stall ? rand_bits(1) : 64'd0;
            cycle_step(r[0]);
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        aw_push = 1'b0;
        w_push  = 1'b0;
        stall   = 1'b1;
        flush   = 1'b1;
        aw_src.delete();
        w_src.delete();
        exp_q.delete();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs  = 0;
        done_cnt   = 0;
        err_pulses = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %-16s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
    endtask

    // run limit scaled from the worst case beat count
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        lfsr_q       = 32'hb3d69e46;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        flush        = 1'b0;
        aw_in        = '0;
        aw_push      = 1'b0;
        w_in         = '0;
        w_push       = 1'b0;
        stall        = 1'b0;
        @(posedge rst_n);

        start_test("reset_state");
        cycle_step(1'b0);
        check_value("beat_valid", 128'(0), 128'(beat_valid));
        check_value("burst_done", 128'(0), 128'(burst_done));
        check_value("last_err", 128'(0), 128'(last_err));
        check_value("aw_full", 128'(0), 128'(aw_full));
        check_value("w_full", 128'(0), 128'(w_full));
        repeat (4) cycle_step(1'b0);
        end_test();

        start_test("no_stall");
        repeat (6) gen_burst(-1, 1'b0);
        drain(1'b0);
        end_test();

        start_test("random_stall");
        repeat (10) gen_burst(-1, 1'b0);
        drain(1'b1);
        end_test();

        start_test("burst_done");
        repeat (6) gen_burst(-1, 1'b0);
        drain(1'b1);
        check_value("done count", 128'(6), 128'(done_cnt));
        end_test();

        // one request and one beat sit past the buffers in controller and output
        start_test("fill_full");
        repeat (5) gen_burst(3, 1'b0);
        n = 0;
        while (!(aw_full && w_full) && n < FILL_WAIT) begin
            cycle_step(1'b1);
            n++;
        end
        check_value("aw_full", 128'(1), 128'(aw_full));
        check_value("w_full", 128'(1), 128'(w_full));
        drain(1'b0);
        end_test();

        start_test("last_err_flush");
        gen_burst(1 + int'(rand_bits(3)), 1'b1);
        drain(1'b0);
        check_value("last_err pulses", 128'(1), 128'(err_pulses));
        // buffer two bursts behind a stall and then throw them away
        repeat (2) gen_burst(-1, 1'b0);
        repeat (12) cycle_step(1'b1);
        flush_all();
        repeat (10) cycle_step(1'b0);
        check_value("beat_valid after flush", 128'(0), 128'(beat_valid));
        gen_burst(-1, 1'b0);
        drain(1'b0);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 40 ns clock, active low reset held for the first 10 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int RST_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/axi_wjoin_top.sv
/*
 * axi write join top
 * request and data buffers feeding a burst controller and output register
 */
`timescale 1ns/1ps
`default_nettype none

module axi_wjoin_top (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // write address requests
    input  axi_wjoin_pkg::aw_req_t              aw_i,
    input  logic                                aw_push_i,
    output logic                                aw_full_o,
    // write data beats
    input  axi_wjoin_pkg::w_beat_t              w_i,
    input  logic                                w_push_i,
    output logic                                w_full_o,
    // joined beat stream
    input  logic                                stall_i,
    output axi_wjoin_pkg::out_beat_t            beat_o,
    output logic                                beat_valid_o,
    // completion and error
    output logic                                burst_done_o,
    output logic [axi_wjoin_pkg::ID_W-1:0]      done_id_o,
    output logic                                last_err_o
);

    // request buffer to controller
    axi_wjoin_pkg::aw_req_t   aw_head;
    logic                     aw_empty;
    logic                     aw_pop;
    // data buffer to controller
    axi_wjoin_pkg::w_beat_t   w_head;
    logic                     w_empty;
    logic                     w_pop;
    // controller to output register
    logic                     out_load;
    logic                     out_accept;
    axi_wjoin_pkg::out_beat_t out_beat;

    axi_fifo #(
        .dtype (axi_wjoin_pkg::aw_req_t),
        .DEPTH (axi_wjoin_pkg::AW_DEPTH)
    ) aw_fifo (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .data_i           (aw_i),
        .push_i           (aw_push_i),
        .pop_i            (aw_pop),
        .data_o           (aw_head),
        .full_o           (aw_full_o),
        .empty_o          (aw_empty),
        .single_element_o ()
    );

    axi_fifo #(
        .dtype (axi_wjoin_pkg::w_beat_t),
        .DEPTH (axi_wjoin_pkg::W_DEPTH)
    ) w_fifo (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .data_i           (w_i),
        .push_i           (w_push_i),
        .pop_i            (w_pop),
        .data_o           (w_head),
        .full_o           (w_full_o),
        .empty_o          (w_empty),
        .single_element_o ()
    );

    wjoin_burst_ctrl burst_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .aw_head_i  (aw_head),
        .aw_empty_i (aw_empty),
        .aw_pop_o   (aw_pop),
        .w_head_i   (w_head),
        .w_empty_i  (w_empty),
        .w_pop_o    (w_pop),
        .accept_i   (out_accept),
        .load_o     (out_load),
        .beat_o     (out_beat),
        .last_err_o (last_err_o)
    );

    wjoin_beat_out beat_out (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .load_i       (out_load),
        .beat_i       (out_beat),
        .stall_i      (stall_i),
        .accept_o     (out_accept),
        .beat_o       (beat_o),
        .beat_valid_o (beat_valid_o),
        .burst_done_o (burst_done_o),
        .done_id_o    (done_id_o)
    );

endmodule

`default_nettype wire

//--- hdl/wjoin_beat_out.sv
/*
 * output beat register
 * holds a beat under stall, tracks burst progress, flags completion
 */
`timescale 1ns/1ps
`default_nettype none

module wjoin_beat_out (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                load_i,
    input  axi_wjoin_pkg::out_beat_t            beat_i,
    input  logic                                stall_i,
    output logic                                accept_o,
    output axi_wjoin_pkg::out_beat_t            beat_o,
    output logic                                beat_valid_o,
    output logic                                burst_done_o,
    output logic [axi_wjoin_pkg::ID_W-1:0]      done_id_o
);

    axi_wjoin_pkg::out_beat_t               beat_q;
    logic                                   valid_q;
    // beat handed downstream this cycle
    logic                                   leave;
    // beats delivered so far in the current burst
    logic [axi_wjoin_pkg::LEN_W-1:0]        cnt_q;
    // address of the first delivered beat of the burst
    logic [axi_wjoin_pkg::ADDR_W-1:0]       base_q;
    logic [axi_wjoin_pkg::ADDR_W-1:0]       exp_addr;

    assign leave    = valid_q && !stall_i;
    // room when empty or draining now
    assign accept_o = !valid_q || !stall_i;

    assign beat_o       = beat_q;
    assign beat_valid_o = valid_q;
    assign burst_done_o = leave && beat_q.last;
    assign done_id_o    = beat_q.id;

    // where the current beat should land given its position
    always_comb begin
        exp_addr = '0;
        exp_addr[axi_wjoin_pkg::LEN_W-1:0] = cnt_q;
        exp_addr = base_q + (exp_addr << $clog2(axi_wjoin_pkg::STRB_W));
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            // a load refills, otherwise a leaving beat empties
            if (load_i) begin
                valid_q <= 1'b1;
            end else if (leave) begin
                valid_q <= 1'b0;
            end
            if (leave) begin
                cnt_q <= beat_q.last ? '0 : cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            beat_q <= beat_i;
        end
        if (leave && cnt_q == '0) begin
            base_q <= beat_q.addr;
        end
    end

    // downstream sees a frozen beat while it stalls
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_q && stall_i && !flush_i |=> valid_q && $stable(beat_q))
        else $error("wjoin_beat_out: beat changed under stall");

    // controller addresses stay contiguous across a burst
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        leave && cnt_q != '0 |-> beat_q.addr == exp_addr)
        else $error("wjoin_beat_out: beat address not incrementing");

endmodule

`default_nettype wire

//--- hdl/wjoin_burst_ctrl.sv
/*
 * burst controller
 * pairs one write request with len+1 data beats and resolves beat addresses
 */
`timescale 1ns/1ps
`default_nettype none

module wjoin_burst_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // request buffer head
    input  axi_wjoin_pkg::aw_req_t   aw_head_i,
    input  logic                     aw_empty_i,
    output logic                     aw_pop_o,
    // data buffer head
    input  axi_wjoin_pkg::w_beat_t   w_head_i,
    input  logic                     w_empty_i,
    output logic                     w_pop_o,
    // output register handshake
    input  logic                     accept_i,
    output logic                     load_o,
    output axi_wjoin_pkg::out_beat_t beat_o,
    // source sent a last flag in the wrong place
    output logic                     last_err_o
);

    axi_wjoin_pkg::burst_state_e            state_q;
    // request being served
    axi_wjoin_pkg::aw_req_t                 req_q;
    // index of the next beat within the burst
    logic [axi_wjoin_pkg::LEN_W-1:0]        cnt_q;
    // beat index widened to address width
    logic [axi_wjoin_pkg::ADDR_W-1:0]       beat_idx;
    // final beat of the burst, from the count
    logic                                   last_calc;
    logic                                   last_err_q;

    assign last_calc = (cnt_q == req_q.len);

    // take a request whenever idle and one is waiting
    assign aw_pop_o = (state_q == axi_wjoin_pkg::IDLE) && !aw_empty_i;
    // move a beat when data is present and the output can take it
    assign load_o   = (state_q == axi_wjoin_pkg::BURST) && !w_empty_i && accept_i;
    assign w_pop_o  = load_o;

    assign last_err_o = last_err_q;

    // zero-extend count before scaling
    always_comb begin
        beat_idx = '0;
        beat_idx[axi_wjoin_pkg::LEN_W-1:0] = cnt_q;
    end

    // joined beat with address base plus bytes per beat times index
    always_comb begin
        beat_o.id   = req_q.id;
        beat_o.addr = req_q.addr + (beat_idx << $clog2(axi_wjoin_pkg::STRB_W));
        beat_o.data = w_head_i.data;
        beat_o.strb = w_head_i.strb;
        // source flag is only checked and never forwarded
        beat_o.last = last_calc;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= axi_wjoin_pkg::IDLE;
            cnt_q      <= '0;
            last_err_q <= 1'b0;
        end else if (flush_i) begin
            state_q    <= axi_wjoin_pkg::IDLE;
            cnt_q      <= '0;
            last_err_q <= 1'b0;
        end else begin
            // one pulse per offending beat
            last_err_q <= load_o && (w_head_i.last != last_calc);
            case (state_q)
                axi_wjoin_pkg::IDLE: begin
                    if (aw_pop_o) begin
                        state_q <= axi_wjoin_pkg::BURST;
                        cnt_q   <= '0;
                    end
                end
                axi_wjoin_pkg::BURST: begin
                    if (load_o) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_calc) begin
                            state_q <= axi_wjoin_pkg::IDLE;
                        end
                    end
                end
                default: state_q <= axi_wjoin_pkg::IDLE;
            endcase
        end
    end

    // latch the request as it leaves the buffer
    always_ff @(posedge clk_i) begin
        if (aw_pop_o) begin
            req_q <= aw_head_i;
        end
    end

    // beat count never runs past the burst length
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == axi_wjoin_pkg::BURST |-> cnt_q <= req_q.len)
        else $error("wjoin_burst_ctrl: beat count beyond burst length");

endmodule

`default_nettype wire

//--- hdl/axi_fifo.sv
/*
 * generic fall-through FIFO
 * circular buffer with occupancy count, flush and status flags
 */
`timescale 1ns/1ps
`default_nettype none

module axi_fifo #(
    parameter type         dtype = logic [63:0],
    parameter int unsigned DEPTH = 4
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    // write side, ignored while full
    input  dtype data_i,
    input  logic push_i,
    // read side, head shown without a clock
    input  logic pop_i,
    output dtype data_o,
    // status
    output logic full_o,
    output logic empty_o,
    output logic single_element_o
);

    // pointers wrap naturally since depth is a power of two
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    // one extra bit so a full buffer is representable
    logic [$clog2(DEPTH):0]   cnt_q;
    // storage
    dtype                     mem_q [DEPTH];
    // qualified strobes
    logic                     do_push;
    logic                     do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o           = (cnt_q == DEPTH[$clog2(DEPTH):0]);
    assign empty_o          = (cnt_q == '0);
    assign single_element_o = (cnt_q == {{$clog2(DEPTH){1'b0}}, 1'b1});

    // head of queue, valid only when not empty
    assign data_o = mem_q[rd_ptr_q];

    // pointer and count update
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // drop everything at once
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (do_pop && !do_push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    initial begin
        assert (DEPTH == 2 ** $clog2(DEPTH))
            else $fatal(1, "axi_fifo: DEPTH must be a power of two");
    end

    // source must watch full_o
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("axi_fifo: push while full, element dropped");

    // sink must watch empty_o
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("axi_fifo: pop while empty");

endmodule

`default_nettype wire

//--- hdl/axi_wjoin_pkg.sv
/*
 * axi write join package
 * widths, buffer depths, request and beat structs, controller states
 */
`default_nettype none

package axi_wjoin_pkg;

    // bus widths
    localparam int unsigned ID_W   = 4;
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    // one strobe bit per byte of a beat
    localparam int unsigned STRB_W = 8;
    // burst length field carries beats minus one
    localparam int unsigned LEN_W  = 4;

    // input buffer depths, powers of two
    localparam int unsigned AW_DEPTH = 4;
    localparam int unsigned W_DEPTH  = 8;

    // write address request as pushed by the source
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } aw_req_t;

    // write data beat as pushed by the source
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // joined beat toward downstream, address already resolved
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } out_beat_t;

    // burst controller states
    typedef enum logic [0:0] {
        IDLE,
        BURST
    } burst_state_e;

endpackage

`default_nettype wire
